// File: source/dds_pkg.sv
`default_nettype none

package dds_pkg;

  // ##########################################################################
  // sizes
  // ##########################################################################

  localparam int PHASE_BITS       = 24;
  localparam int QUANT_BITS       = 14;   // phase bits dropped before the table
  localparam int LUT_ADDR_BITS    = PHASE_BITS - QUANT_BITS;
  localparam int LUT_DEPTH        = 2 ** LUT_ADDR_BITS;
  localparam int OUTPUT_WIDTH     = 18;
  localparam int PARALLEL_SAMPLES = 4;
  localparam int PIPE_DEPTH       = 5;    // advancing stages from increment to beat

  localparam int LFSR_BITS = 16;
  localparam logic [LFSR_BITS-1:0] LFSR_TAPS = 16'hB400;

  localparam real PI = 3.14159265358979;

  // ##########################################################################
  // types
  // ##########################################################################

  typedef logic [PHASE_BITS-1:0] phase_t;
  typedef logic signed [OUTPUT_WIDTH-1:0] sample_t;
  typedef logic [LUT_ADDR_BITS-1:0] lut_addr_t;
  typedef logic [LFSR_BITS-1:0] lfsr_word_t;

  // lane 0 is the earliest sample of a beat
  typedef struct packed {
    phase_t [PARALLEL_SAMPLES-1:0] phase;
  } phase_vec_t;

  typedef struct packed {
    lut_addr_t [PARALLEL_SAMPLES-1:0] addr;
  } addr_vec_t;

  typedef struct packed {
    lfsr_word_t [PARALLEL_SAMPLES-1:0] word;
  } dither_vec_t;

  typedef struct packed {
    sample_t [PARALLEL_SAMPLES-1:0] samples;  // lane 0 in the low bits
  } cos_beat_t;

  typedef struct packed {
    logic   valid;
    phase_t inc;
  } inc_req_t;

endpackage

`default_nettype wire

// File: source/lfsr16_parallel.sv
`default_nettype none

module lfsr16_parallel (
  input wire clk,
  input wire reset,
  input wire advance,
  output dds_pkg::dither_vec_t dither
);

  import dds_pkg::*;

  lfsr_word_t [PARALLEL_SAMPLES-1:0] state;

  // one Galois step, shifting right and folding the taps back in
  function automatic lfsr_word_t lfsr_step(input lfsr_word_t s);
    lfsr_word_t next;
    next = s >> 1;
    if (s[0]) begin
      next = next ^ LFSR_TAPS;
    end
    return next;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
        state[i] <= LFSR_BITS'(i + 1);  // distinct nonzero seeds per lane
      end
    end else if (advance) begin
      for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
        state[i] <= lfsr_step(state[i]);
      end
    end
  end

  assign dither.word = state;

endmodule

`default_nettype wire

// File: source/phase_accumulator.sv
`default_nettype none

module phase_accumulator (
  input wire clk,
  input wire reset,
  input wire dds_pkg::inc_req_t inc_req,
  input wire advance,
  output logic pinc_change,
  output dds_pkg::phase_vec_t sample_phase
);

  import dds_pkg::*;

  // inc_mult[i] holds (i + 1) times the increment
  phase_t [PARALLEL_SAMPLES-1:0] inc_mult;
  phase_t [PARALLEL_SAMPLES-1:0] mult_next;
  phase_t cycle_phase;

  // ##########################################################################
  // increment load
  // ##########################################################################

  // running sum instead of a multiplier, only used when a new increment lands
  always_comb begin
    mult_next[0] = inc_req.inc;
    for (int i = 1; i < PARALLEL_SAMPLES; i++) begin
      mult_next[i] = mult_next[i-1] + inc_req.inc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      inc_mult    <= '0;
      pinc_change <= 1'b0;
    end else begin
      pinc_change <= inc_req.valid;  // input has no ready, taken every time
      if (inc_req.valid) begin
        inc_mult <= mult_next;
      end
    end
  end

  // ##########################################################################
  // accumulation
  // ##########################################################################

  // each lane adds its own multiple to the cycle phase so the lane adders
  // stay one deep
  always_ff @(posedge clk) begin
    if (reset) begin
      cycle_phase  <= '0;
      sample_phase <= '0;
    end else if (advance) begin
      cycle_phase <= cycle_phase + inc_mult[PARALLEL_SAMPLES-1];
      sample_phase.phase[0] <= cycle_phase;
      for (int i = 1; i < PARALLEL_SAMPLES; i++) begin
        sample_phase.phase[i] <= cycle_phase + inc_mult[i-1];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/phase_dither_quantizer.sv
`default_nettype none

module phase_dither_quantizer (
  input wire clk,
  input wire reset,
  input wire advance,
  input wire dither_enable,
  input wire dds_pkg::phase_vec_t sample_phase,
  input wire dds_pkg::dither_vec_t dither,
  output dds_pkg::addr_vec_t addr
);

  import dds_pkg::*;

  phase_t [PARALLEL_SAMPLES-1:0] dither_add;
  phase_vec_t dithered;

  // dither covers the dropped phase bits, scaled up when they outnumber
  // the LFSR bits
  for (genvar i = 0; i < PARALLEL_SAMPLES; i++) begin : g_lane
    if (QUANT_BITS > LFSR_BITS) begin : g_wide
      assign dither_add[i] = dither_enable ?
        phase_t'({dither.word[i], {(QUANT_BITS - LFSR_BITS){1'b0}}}) : '0;
    end else begin : g_narrow
      assign dither_add[i] = dither_enable ?
        phase_t'(dither.word[i][QUANT_BITS-1:0]) : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dithered <= '0;
      addr     <= '0;
    end else if (advance) begin
      for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
        dithered.phase[i] <= sample_phase.phase[i] + dither_add[i];
        addr.addr[i] <= dithered.phase[i][PHASE_BITS-1:QUANT_BITS];  // truncate
      end
    end
  end

endmodule

`default_nettype wire

// File: source/cosine_output_stage.sv
`default_nettype none

module cosine_output_stage (
  input wire clk,
  input wire reset,
  input wire dds_pkg::addr_vec_t addr,
  input wire cos_ready,
  output logic cos_valid,
  output dds_pkg::cos_beat_t cos_beat,
  output logic advance
);

  import dds_pkg::*;

  sample_t cos_table [LUT_DEPTH];
  logic [PIPE_DEPTH-1:0] valid_pipe;

  // ##########################################################################
  // cosine table
  // ##########################################################################

  // scaled so the peak stays half an LSB inside the signed range
  function automatic sample_t cos_entry(input int k);
    real angle;
    real scale;
    real value;
    angle = 2.0 * PI * k / LUT_DEPTH;
    scale = 2.0 ** (OUTPUT_WIDTH - 1) - 0.5;
    value = $floor($cos(angle) * scale - 0.5);
    return sample_t'($rtoi(value));
  endfunction

  initial begin
    for (int k = 0; k < LUT_DEPTH; k++) begin
      cos_table[k] = cos_entry(k);
    end
  end

  // ##########################################################################
  // output register and flow control
  // ##########################################################################

  assign advance   = cos_ready || !cos_valid;  // hold everything while stalled
  assign cos_valid = valid_pipe[PIPE_DEPTH-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_pipe <= '0;
      cos_beat   <= '0;
    end else if (advance) begin
      valid_pipe <= {valid_pipe[PIPE_DEPTH-2:0], 1'b1};
      for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
        cos_beat.samples[i] <= cos_table[addr.addr[i]];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/dds.sv
`default_nettype none

module dds (
  input wire clk,
  input wire reset,
  input wire dds_pkg::inc_req_t inc_req,
  input wire dither_enable,
  output logic pinc_change,
  output logic cos_valid,
  input wire cos_ready,
  output dds_pkg::cos_beat_t cos_beat
);

  import dds_pkg::*;

  logic advance;  // from the output stage, steps the whole pipeline
  phase_vec_t sample_phase;
  dither_vec_t dither;
  addr_vec_t addr;

  phase_accumulator phase_accumulator_inst (
    .clk          (clk),
    .reset        (reset),
    .inc_req      (inc_req),
    .advance      (advance),
    .pinc_change  (pinc_change),
    .sample_phase (sample_phase)
  );

  lfsr16_parallel lfsr16_parallel_inst (
    .clk     (clk),
    .reset   (reset),
    .advance (advance),
    .dither  (dither)
  );

  phase_dither_quantizer phase_dither_quantizer_inst (
    .clk           (clk),
    .reset         (reset),
    .advance       (advance),
    .dither_enable (dither_enable),
    .sample_phase  (sample_phase),
    .dither        (dither),
    .addr          (addr)
  );

  cosine_output_stage cosine_output_stage_inst (
    .clk       (clk),
    .reset     (reset),
    .addr      (addr),
    .cos_ready (cos_ready),
    .cos_valid (cos_valid),
    .cos_beat  (cos_beat),
    .advance   (advance)
  );

endmodule

`default_nettype wire

// File: testbench/dds_tb.sv
`default_nettype none

module dds_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import dds_pkg::*;

  localparam int NUM_INCS      = 7;
  localparam int BEATS_PER_INC = 40;
  localparam int DITHER_BEATS  = 60;
  localparam int TOTAL_BEATS   = NUM_INCS * BEATS_PER_INC + DITHER_BEATS;
  localparam int WATCHDOG_NS   = TOTAL_BEATS * 20 * 10 + 2000;
  localparam int MIN_CHECKED   = NUM_INCS * (BEATS_PER_INC - PIPE_DEPTH - 2);

  // multiples of 2^QUANT_BITS, 0x7FC000 steps by 511 and wraps the table every beat
  localparam phase_t INCS [NUM_INCS] = '{
    24'h004000, 24'h7FC000, 24'h0A4000, 24'h124000, 24'hF1C000, 24'h3C4000, 24'h028000
  };

  logic clk = 1'b0;
  logic reset;
  inc_req_t inc_req;
  logic dither_enable;
  logic pinc_change;
  logic cos_valid;
  logic cos_ready;
  cos_beat_t cos_beat;

  sample_t ref_table [LUT_DEPTH];
  logic [31:0] rng_state = 32'd38;
  logic random_ready;
  logic dither_check;
  phase_t active_inc;

  int beat_count = 0;
  int checked_beats = 0;
  int beat_errors = 0;
  int pulse_errors = 0;
  int other_errors = 0;
  int discard = 0;
  int step = 0;
  int next_addr = 0;
  bit tracking = 1'b0;
  bit synced = 1'b0;
  bit stalled = 1'b0;
  logic last_inc_valid = 1'b0;
  cos_beat_t held_beat;

  dds dds_inst (
    .clk           (clk),
    .reset         (reset),
    .inc_req       (inc_req),
    .dither_enable (dither_enable),
    .pinc_change   (pinc_change),
    .cos_valid     (cos_valid),
    .cos_ready     (cos_ready),
    .cos_beat      (cos_beat)
  );

  always #5 clk = ~clk;

  // ##########################################################################
  // reference model
  // ##########################################################################

  function automatic sample_t ref_cos(input int k);
    real angle;
    real scale;
    real value;
    angle = 2.0 * PI * k / LUT_DEPTH;
    scale = 2.0 ** (OUTPUT_WIDTH - 1) - 0.5;
    value = $floor($cos(angle) * scale - 0.5);
    return sample_t'($rtoi(value));
  endfunction

  // lane i of a beat sits i table steps after the beat's base address
  function automatic cos_beat_t predict_beat(input int base, input int stride);
    cos_beat_t beat;
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      beat.samples[i] = ref_table[(base + i * stride) % LUT_DEPTH];
    end
    return beat;
  endfunction

  function automatic int find_start(input cos_beat_t beat, input int stride);
    for (int a = 0; a < LUT_DEPTH; a++) begin
      if (predict_beat(a, stride) == beat) begin
        return a;
      end
    end
    return -1;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ##########################################################################
  // checks and stimulus
  // ##########################################################################

  task automatic check_beat(input string name, input cos_beat_t actual,
                            input cos_beat_t expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got %h, expected %h", name, actual, expected);
      beat_errors++;
    end
  endtask

  task automatic check_pulse(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got %h, expected %h", name, actual, expected);
      pulse_errors++;
    end
  endtask

  task automatic send_increment(input phase_t value);
    @(posedge clk);
    inc_req    <= '{valid: 1'b1, inc: value};
    active_inc <= value;
    @(posedge clk);
    inc_req <= '{valid: 1'b0, inc: value};
  endtask

  task automatic wait_beats(input int n);
    int target;
    target = beat_count + n;
    while (beat_count < target) begin
      @(posedge clk);
    end
  endtask

  // valid comes out of a five deep delay line that fills while nothing is valid
  task automatic check_reset_timing();
    @(negedge clk);
    check_pulse("cos_valid", cos_valid, 1'b0);
    check_pulse("pinc_change", pinc_change, 1'b0);
    for (int n = 1; n <= PIPE_DEPTH; n++) begin
      @(negedge clk);
      check_pulse("cos_valid", cos_valid, n == PIPE_DEPTH);
    end
  endtask

  always @(posedge clk) begin
    rng_state = xorshift32(rng_state);
    cos_ready <= random_ready ? rng_state[3] : 1'b1;
  end

  // ##########################################################################
  // compare process
  // ##########################################################################

  always @(negedge clk) begin : compare
    cos_beat_t expected;
    int start;
    if (reset) begin
      last_inc_valid = 1'b0;
      stalled = 1'b0;
    end else begin
      check_pulse("pinc_change", pinc_change, last_inc_valid);
      last_inc_valid = inc_req.valid;
      if (stalled) begin
        if (!cos_valid) begin
          $display("cos_valid dropped while a beat was waiting for ready");
          other_errors++;
        end
        check_beat("cos_beat", cos_beat, held_beat);
      end
      stalled = cos_valid && !cos_ready;
      held_beat = cos_beat;
      if (pinc_change) begin  // restart the prediction for the new increment
        tracking = 1'b1;
        synced = 1'b0;
        discard = PIPE_DEPTH + 1;
        step = int'(active_inc >> QUANT_BITS);
      end
      if (cos_valid && cos_ready) begin
        beat_count++;
        if (tracking && discard > 0) begin
          discard--;
        end else if (tracking && !synced) begin
          start = find_start(cos_beat, step);
          if (start < 0) begin
            $display("no table address matches the first beat after increment %h", active_inc);
            other_errors++;
            tracking = 1'b0;
          end else begin
            synced = 1'b1;
            next_addr = (start + PARALLEL_SAMPLES * step) % LUT_DEPTH;
          end
        end else if (synced) begin
          expected = predict_beat(next_addr, step);
          if (dither_check) begin
            // dither may push a lane one address further
            for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
              if (cos_beat.samples[i] == ref_table[(next_addr + i * step + 1) % LUT_DEPTH]) begin
                expected.samples[i] = cos_beat.samples[i];
              end
            end
          end
          check_beat("cos_beat", cos_beat, expected);
          checked_beats++;
          next_addr = (next_addr + PARALLEL_SAMPLES * step) % LUT_DEPTH;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the DUT stopped delivering beats", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  // ##########################################################################
  // main sequence
  // ##########################################################################

  initial begin
    reset = 1'b1;
    inc_req = '0;
    dither_enable = 1'b0;
    cos_ready = 1'b1;
    random_ready = 1'b0;
    dither_check = 1'b0;
    active_inc = '0;
    for (int k = 0; k < LUT_DEPTH; k++) begin
      ref_table[k] = ref_cos(k);
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    check_reset_timing();
    for (int n = 0; n < NUM_INCS; n++) begin
      if (n == 3) begin
        random_ready <= 1'b1;  // back-pressure from here on
      end
      send_increment(INCS[n]);
      wait_beats(BEATS_PER_INC);
    end
    @(posedge clk);
    dither_enable <= 1'b1;
    dither_check <= 1'b1;
    wait_beats(DITHER_BEATS);
    if (checked_beats < MIN_CHECKED) begin
      $display("only %0d beats were checked against the prediction", checked_beats);
      other_errors++;
    end
    $display("errors: beat %0d, pulse %0d, other %0d", beat_errors, pulse_errors,
             other_errors);
    if (beat_errors + pulse_errors + other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
source/dds_pkg.sv
source/lfsr16_parallel.sv
source/phase_accumulator.sv
source/phase_dither_quantizer.sv
source/cosine_output_stage.sv
source/dds.sv
testbench/dds_tb.sv

// File: Makefile
# Verilator build and run for the DDS testbench

VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       = dds_tb
FILE_LIST = all.f
BIN       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "TEST PASSED"

clean:
	rm -rf obj_dir
